// File: fp_add_unit.f
common/fp_format_pkg.sv
common/fp_ops_pkg.sv
common/fpadd_result_if.sv
fp_adder/count_leading_zeros.sv
fp_adder/floating_point_adder.sv
src/fp_rounder.sv
src/fp_add_unit.sv
tb/tb_fp_add_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run tb_fp_add_unit with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

obj_dir="obj_dir"
log_file="sim.log"

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_fp_add_unit --Mdir "$obj_dir" -o sim_fp_add_unit \
        -f fp_add_unit.f; then
    echo "verilator compile failed"
    exit 1
fi

"./$obj_dir/sim_fp_add_unit" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "TEST FAILED" "$log_file"; then
    echo "simulation reported a failure, see $log_file"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

// File: tb/tb_fp_add_unit.sv
`timescale 1ns/10ps

module tb_fp_add_unit;

    // reset, about 12 single ops and two 10-op streams need a few hundred cycles.
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int LATENCY        = 5;
    localparam int STREAM_LEN     = 10;

    localparam logic [31:0] F_ONE   = 32'h3F80_0000;
    localparam logic [31:0] F_TWO   = 32'h4000_0000;
    localparam logic [31:0] F_THREE = 32'h4040_0000;
    localparam logic [31:0] F_INF   = 32'h7F80_0000;
    localparam logic [31:0] F_MAX   = 32'h7F7F_FFFF;

    localparam fp_ops_pkg::fp_flags_t NO_FLAGS = 4'b0000;
    localparam fp_ops_pkg::fp_flags_t INEXACT  = 4'b0001;
    localparam fp_ops_pkg::fp_flags_t OVERFLOW = 4'b0100;
    localparam fp_ops_pkg::fp_flags_t INVALID  = 4'b1000;

    logic                         clk;
    logic                         rst_n;
    logic                         clk_en;
    fp_format_pkg::float32_t      op_a;
    fp_format_pkg::float32_t      op_b;
    fp_ops_pkg::fpadd_operation_t operation;
    fp_ops_pkg::round_mode_t      rnd_mode;
    logic                         valid_in;
    fp_format_pkg::float32_t      result;
    logic                         valid_out;
    fp_ops_pkg::fp_flags_t        flags;

    integer seed        = 15;
    int     cycle_count = 0;

    fp_add_unit dut0 (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .clk_en_i    (clk_en),
        .op_a_i      (op_a),
        .op_b_i      (op_b),
        .operation_i (operation),
        .rnd_mode_i  (rnd_mode),
        .valid_i     (valid_in),
        .result_o    (result),
        .valid_o     (valid_out),
        .flags_o     (flags)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #2 clk = ~clk;
    end : clock_gen

    always @(posedge clk) begin : watchdog
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("simulation timed out after %0d cycles", TIMEOUT_CYCLES);
            stop_on_error();
        end
    end : watchdog

    // ----------------------------------------------------------------------
    // checks and helpers.
    // ----------------------------------------------------------------------

    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_result(input string name, input fp_format_pkg::float32_t expected,
                                input fp_format_pkg::float32_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected result %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_flags(input string name, input fp_ops_pkg::fp_flags_t expected,
                               input fp_ops_pkg::fp_flags_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected flags %b, actual %b", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAILED %s: expected latency %0d, actual %0d", name, expected, actual);
            stop_on_error();
        end
    endtask

    // exact normal values and zero only.
    function automatic fp_format_pkg::float32_t real_to_float32(input real value);
        logic [63:0]             bits;
        fp_format_pkg::float32_t f;
        bits = $realtobits(value);
        f    = {bits[63], 31'b0};
        if (bits[62:0] != '0) begin
            // rebias from 1023 to 127.
            f.exponent = 8'(bits[62:52] - 11'd896);
            f.mantissa = bits[51:29];
        end
        return f;
    endfunction

    task automatic drive_op(input fp_format_pkg::float32_t a, input fp_format_pkg::float32_t b,
                            input fp_ops_pkg::fpadd_operation_t op,
                            input fp_ops_pkg::round_mode_t mode);
        op_a      = a;
        op_b      = b;
        operation = op;
        rnd_mode  = mode;
        valid_in  = 1'b1;
    endtask

    // one operation, then wait for valid_o and check everything.
    task automatic run_single(input string name, input fp_format_pkg::float32_t a,
                              input fp_format_pkg::float32_t b,
                              input fp_ops_pkg::fpadd_operation_t op,
                              input fp_ops_pkg::round_mode_t mode,
                              input fp_format_pkg::float32_t exp_res,
                              input fp_ops_pkg::fp_flags_t exp_flags);
        int waited;
        waited = 0;
        @(negedge clk);
        drive_op(a, b, op, mode);
        do begin
            @(negedge clk);
            valid_in = 1'b0;
            waited++;
            if (waited > 4 * LATENCY) begin
                $display("%s: valid_o did not rise within %0d cycles", name, waited);
                stop_on_error();
            end
        end while (!valid_out);
        check_latency(name, LATENCY, waited);
        check_result(name, exp_res, result);
        check_flags(name, exp_flags, flags);
    endtask

    // ----------------------------------------------------------------------
    // directed tests.
    // ----------------------------------------------------------------------

    task automatic test_exact_add_sub();
        run_single("1.0 + 2.0", F_ONE, F_TWO, fp_ops_pkg::FADD, fp_ops_pkg::RNE,
                   F_THREE, NO_FLAGS);
        run_single("3.0 - 1.0", F_THREE, F_ONE, fp_ops_pkg::FSUB, fp_ops_pkg::RNE,
                   F_TWO, NO_FLAGS);
        run_single("2.0 - 3.0", F_TWO, F_THREE, fp_ops_pkg::FSUB, fp_ops_pkg::RNE,
                   32'hBF80_0000, NO_FLAGS);
        // 2.5 - 2.5 cancels to +0.
        run_single("2.5 - 2.5", 32'h4020_0000, 32'h4020_0000, fp_ops_pkg::FSUB,
                   fp_ops_pkg::RNE, 32'h0000_0000, NO_FLAGS);
    endtask

    task automatic test_rounding_modes();
        // 1 + 1.5 ulp ties on an odd last bit and rne rounds it up.
        run_single("1.0 + 3*2^-24 rne", F_ONE, 32'h3440_0000, fp_ops_pkg::FADD,
                   fp_ops_pkg::RNE, 32'h3F80_0002, INEXACT);
        run_single("1.0 + 3*2^-24 rtz", F_ONE, 32'h3440_0000, fp_ops_pkg::FADD,
                   fp_ops_pkg::RTZ, 32'h3F80_0001, INEXACT);
        // half an ulp on an even last bit stays put.
        run_single("1.0 + 2^-24 rne", F_ONE, 32'h3380_0000, fp_ops_pkg::FADD,
                   fp_ops_pkg::RNE, F_ONE, INEXACT);
    endtask

    task automatic test_invalid_ops();
        run_single("nan + 1.0", 32'h7F80_0001, F_ONE, fp_ops_pkg::FADD, fp_ops_pkg::RNE,
                   fp_format_pkg::CANONICAL_NAN, INVALID);
        run_single("inf - inf", F_INF, F_INF, fp_ops_pkg::FSUB, fp_ops_pkg::RNE,
                   fp_format_pkg::CANONICAL_NAN, INVALID);
        run_single("inf + 1.0", F_INF, F_ONE, fp_ops_pkg::FADD, fp_ops_pkg::RNE,
                   F_INF, NO_FLAGS);
    endtask

    task automatic test_overflow();
        run_single("max + max", F_MAX, F_MAX, fp_ops_pkg::FADD, fp_ops_pkg::RNE,
                   F_INF, OVERFLOW);
    endtask

    // back-to-back exact integer sums with an optional 3-cycle stall midway.
    task automatic run_stream(input string name, input bit with_stall);
        fp_format_pkg::float32_t      a_arr [STREAM_LEN];
        fp_format_pkg::float32_t      b_arr [STREAM_LEN];
        fp_ops_pkg::fpadd_operation_t op_arr [STREAM_LEN];
        fp_format_pkg::float32_t      expected_q [$];
        fp_format_pkg::float32_t      held_res;
        fp_ops_pkg::fp_flags_t        held_flags;
        int                           ia;
        int                           ib;
        real                          sum;
        int                           n_sent;
        int                           n_recv;
        int                           waited;
        bit                           stalled;
        for (int i = 0; i < STREAM_LEN; i++) begin
            // below 2^20 in magnitude, so every sum is exact.
            ia        = $random(seed) % 1048576;
            ib        = $random(seed) % 1048576;
            op_arr[i] = ($random(seed) & 1) ? fp_ops_pkg::FSUB : fp_ops_pkg::FADD;
            a_arr[i]  = real_to_float32($itor(ia));
            b_arr[i]  = real_to_float32($itor(ib));
            sum = (op_arr[i] == fp_ops_pkg::FSUB) ? $itor(ia) - $itor(ib)
                                                  : $itor(ia) + $itor(ib);
            expected_q.push_back(real_to_float32(sum));
        end
        n_sent  = 0;
        n_recv  = 0;
        waited  = 0;
        stalled = 1'b0;
        while (n_recv < STREAM_LEN) begin
            @(negedge clk);
            waited++;
            if (valid_out) begin
                check_result(name, expected_q.pop_front(), result);
                check_flags(name, NO_FLAGS, flags);
                n_recv++;
            end else if (n_recv > 0) begin
                $display("%s: result stream has a gap after %0d results", name, n_recv);
                stop_on_error();
            end else if (waited > STREAM_LEN + 4 * LATENCY) begin
                $display("%s: no result arrived within %0d cycles", name, waited);
                stop_on_error();
            end
            if (n_sent < STREAM_LEN) begin
                drive_op(a_arr[n_sent], b_arr[n_sent], op_arr[n_sent], fp_ops_pkg::RNE);
                n_sent++;
            end else begin
                valid_in = 1'b0;
            end
            if (with_stall && !stalled && n_recv == STREAM_LEN / 2) begin
                stalled    = 1'b1;
                held_res   = result;
                held_flags = flags;
                clk_en     = 1'b0;
                repeat (3) begin
                    @(negedge clk);
                    if (!valid_out) begin
                        $display("%s: valid_o dropped while clk_en_i was low", name);
                        stop_on_error();
                    end
                    check_result(name, held_res, result);
                    check_flags(name, held_flags, flags);
                end
                // op already on the inputs is taken at the next enabled edge.
                clk_en = 1'b1;
            end
        end
    endtask

    task automatic test_stream();
        run_stream("stream back to back", 1'b0);
        run_stream("stream with stall", 1'b1);
    endtask

    // ----------------------------------------------------------------------
    // main sequence.
    // ----------------------------------------------------------------------

    initial begin : main
        rst_n     = 1'b0;
        clk_en    = 1'b1;
        op_a      = '0;
        op_b      = '0;
        operation = fp_ops_pkg::FADD;
        rnd_mode  = fp_ops_pkg::RNE;
        valid_in  = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        test_exact_add_sub();
        test_rounding_modes();
        test_invalid_ops();
        test_overflow();
        test_stream();

        $display("TEST PASSED");
        $finish;
    end : main

endmodule : tb_fp_add_unit

// File: src/fp_add_unit.sv
`timescale 1ns/10ps

module fp_add_unit (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         clk_en_i,
    input  fp_format_pkg::float32_t      op_a_i,
    input  fp_format_pkg::float32_t      op_b_i,
    input  fp_ops_pkg::fpadd_operation_t operation_i,
    input  fp_ops_pkg::round_mode_t      rnd_mode_i,
    input  logic                         valid_i,
    output fp_format_pkg::float32_t      result_o,
    output logic                         valid_o,
    output fp_ops_pkg::fp_flags_t        flags_o
);

    // unrounded sum from the adder to the rounder.
    fpadd_result_if add_res_if ();

    // four-stage add/subtract.
    floating_point_adder u_adder (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clk_en_i     (clk_en_i),
        .addend_a_i   (op_a_i),
        .addend_b_i   (op_b_i),
        .operation_i  (operation_i),
        .rnd_mode_i   (rnd_mode_i),
        .data_valid_i (valid_i),
        .res_o        (add_res_if.producer)
    );

    // final rounding and flags, one more stage.
    fp_rounder u_rounder (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .clk_en_i (clk_en_i),
        .res_i    (add_res_if.consumer),
        .result_o (result_o),
        .valid_o  (valid_o),
        .flags_o  (flags_o)
    );

endmodule : fp_add_unit

// File: src/fp_rounder.sv
`timescale 1ns/10ps

module fp_rounder (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    clk_en_i,
    fpadd_result_if.consumer        res_i,
    output fp_format_pkg::float32_t result_o,
    output logic                    valid_o,
    output fp_ops_pkg::fp_flags_t   flags_o
);

    // ----------------------------------------------------------------------
    // rounding increment.
    // ----------------------------------------------------------------------

    logic                    round_up;
    logic                    any_round_bit;
    logic [23:0]             mant_inc;
    logic [7:0]              exp_inc;
    logic                    round_ovf;
    fp_format_pkg::float32_t rounded;
    fp_ops_pkg::fp_flags_t   flags_d;

    assign any_round_bit = res_i.round_bits.guard | res_i.round_bits.round |
                           res_i.round_bits.sticky;

    // rtz never increments.
    assign round_up = (res_i.rnd_mode == fp_ops_pkg::RNE) & res_i.round_bits.guard &
                      (res_i.round_bits.round | res_i.round_bits.sticky |
                       res_i.result.mantissa[0]);

    assign mant_inc = {1'b0, res_i.result.mantissa} + {23'b0, round_up};

    // mantissa carry bumps the exponent, subnormal to normal included.
    assign exp_inc   = res_i.result.exponent + {7'b0, mant_inc[23]};
    assign round_ovf = mant_inc[23] & (res_i.result.exponent == fp_format_pkg::MAX_EXP);

    always_comb begin : final_result
        // on round_ovf this already encodes infinity.
        rounded = {res_i.result.sign, exp_inc, mant_inc[22:0]};
        if (res_i.invalid) begin
            rounded = fp_format_pkg::CANONICAL_NAN;
        end
    end : final_result

    assign flags_d.invalid   = res_i.invalid;
    assign flags_d.overflow  = res_i.overflow | round_ovf;
    assign flags_d.underflow = res_i.underflow;
    assign flags_d.inexact   = ~res_i.invalid & any_round_bit;

    // ----------------------------------------------------------------------
    // output register.
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin : valid_reg
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (clk_en_i) begin
            valid_o <= res_i.valid;
        end
    end : valid_reg

    always_ff @(posedge clk_i) begin : data_reg
        if (clk_en_i) begin
            result_o <= rounded;
            flags_o  <= flags_d;
        end
    end : data_reg

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && flags_o.invalid) |-> (result_o == fp_format_pkg::CANONICAL_NAN));

endmodule : fp_rounder

// File: fp_adder/floating_point_adder.sv
`timescale 1ns/10ps

module floating_point_adder (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         clk_en_i,
    input  fp_format_pkg::float32_t      addend_a_i,
    input  fp_format_pkg::float32_t      addend_b_i,
    input  fp_ops_pkg::fpadd_operation_t operation_i,
    input  fp_ops_pkg::round_mode_t      rnd_mode_i,
    input  logic                         data_valid_i,
    fpadd_result_if.producer             res_o
);

    localparam int SIG_W = fp_format_pkg::MANT_W + 1;
    localparam int LZ_W  = $clog2(SIG_W + 1);

    // ----------------------------------------------------------------------
    // valid pipeline.
    // ----------------------------------------------------------------------

    logic [3:0] valid_pipe;

    always_ff @(posedge clk_i) begin : valid_shift
        if (!rst_n_i) begin
            valid_pipe <= '0;
        end else if (clk_en_i) begin
            valid_pipe <= {valid_pipe[2:0], data_valid_i};
        end
    end : valid_shift

    assert property (@(posedge clk_i) disable iff (!rst_n_i) !$isunknown(valid_pipe));

    // ----------------------------------------------------------------------
    // stage 0: specials, operand order, exponent difference.
    // ----------------------------------------------------------------------

    fp_format_pkg::float32_t addend_b_eff;
    fp_format_pkg::float32_t major;
    fp_format_pkg::float32_t minor;
    logic                    a_is_nan;
    logic                    b_is_nan;
    logic                    a_is_inf;
    logic                    b_is_inf;
    logic                    a_ge_b;
    logic [7:0]              major_exp_eff;
    logic [7:0]              minor_exp_eff;

    assign addend_b_eff = {addend_b_i.sign ^ (operation_i == fp_ops_pkg::FSUB),
                           addend_b_i.exponent, addend_b_i.mantissa};

    assign a_is_nan = (addend_a_i.exponent == fp_format_pkg::INF_EXP) &&
                      (addend_a_i.mantissa != '0);
    assign b_is_nan = (addend_b_i.exponent == fp_format_pkg::INF_EXP) &&
                      (addend_b_i.mantissa != '0);
    assign a_is_inf = (addend_a_i.exponent == fp_format_pkg::INF_EXP) &&
                      (addend_a_i.mantissa == '0);
    assign b_is_inf = (addend_b_i.exponent == fp_format_pkg::INF_EXP) &&
                      (addend_b_i.mantissa == '0);

    // full magnitude compare, so the aligned subtraction never goes negative.
    assign a_ge_b = {addend_a_i.exponent, addend_a_i.mantissa} >=
                    {addend_b_i.exponent, addend_b_i.mantissa};
    assign major  = a_ge_b ? addend_a_i : addend_b_eff;
    assign minor  = a_ge_b ? addend_b_eff : addend_a_i;

    // subnormals sit on the same scale as exponent 1.
    assign major_exp_eff = (major.exponent == '0) ? fp_format_pkg::MIN_EXP : major.exponent;
    assign minor_exp_eff = (minor.exponent == '0) ? fp_format_pkg::MIN_EXP : minor.exponent;

    logic                    major_sign_s0;
    logic [7:0]              major_exp_s0;
    logic [SIG_W-1:0]        major_sig_s0;
    logic                    minor_sign_s0;
    logic [SIG_W-1:0]        minor_sig_s0;
    logic [7:0]              exp_diff_s0;
    logic                    invalid_s0;
    logic                    inf_s0;
    fp_ops_pkg::round_mode_t rnd_mode_s0;

    always_ff @(posedge clk_i) begin : stage0_reg
        if (clk_en_i) begin
            major_sign_s0 <= major.sign;
            major_exp_s0  <= major_exp_eff;
            major_sig_s0  <= {major.exponent != '0, major.mantissa};
            minor_sign_s0 <= minor.sign;
            minor_sig_s0  <= {minor.exponent != '0, minor.mantissa};
            exp_diff_s0   <= major_exp_eff - minor_exp_eff;
            // nan operand, or infinities that cancel.
            invalid_s0    <= a_is_nan | b_is_nan |
                             (a_is_inf & b_is_inf & (addend_a_i.sign ^ addend_b_eff.sign));
            inf_s0        <= a_is_inf | b_is_inf;
            rnd_mode_s0   <= rnd_mode_i;
        end
    end : stage0_reg

    // ----------------------------------------------------------------------
    // stage 1: align minor significand.
    // ----------------------------------------------------------------------

    logic [49:0] minor_shifted;
    logic [26:0] minor_ext;

    assign minor_shifted = {minor_sig_s0, 26'b0} >> exp_diff_s0;

    // layout is significand, guard, round, sticky.
    assign minor_ext = (exp_diff_s0 >= 8'd26) ? {26'b0, |minor_sig_s0}
                                              : {minor_shifted[49:24], |minor_shifted[23:0]};

    logic                    major_sign_s1;
    logic [7:0]              major_exp_s1;
    logic [SIG_W-1:0]        major_sig_s1;
    logic                    minor_sign_s1;
    logic [26:0]             minor_ext_s1;
    logic                    invalid_s1;
    logic                    inf_s1;
    fp_ops_pkg::round_mode_t rnd_mode_s1;

    always_ff @(posedge clk_i) begin : stage1_reg
        if (clk_en_i) begin
            major_sign_s1 <= major_sign_s0;
            major_exp_s1  <= major_exp_s0;
            major_sig_s1  <= major_sig_s0;
            minor_sign_s1 <= minor_sign_s0;
            minor_ext_s1  <= minor_ext;
            invalid_s1    <= invalid_s0;
            inf_s1        <= inf_s0;
            rnd_mode_s1   <= rnd_mode_s0;
        end
    end : stage1_reg

    // ----------------------------------------------------------------------
    // stage 2: significand add or subtract.
    // ----------------------------------------------------------------------

    logic        eff_sub;
    logic [27:0] major_ext;
    logic [27:0] sum;

    assign eff_sub   = major_sign_s1 ^ minor_sign_s1;
    assign major_ext = {1'b0, major_sig_s1, 3'b000};
    assign sum       = eff_sub ? (major_ext - {1'b0, minor_ext_s1})
                               : (major_ext + {1'b0, minor_ext_s1});

    logic                    sign_s2;
    logic [7:0]              exp_s2;
    logic [26:0]             sum_s2;
    logic                    carry_s2;
    logic                    eff_sub_s2;
    logic                    invalid_s2;
    logic                    inf_s2;
    fp_ops_pkg::round_mode_t rnd_mode_s2;

    always_ff @(posedge clk_i) begin : stage2_reg
        if (clk_en_i) begin
            sign_s2     <= major_sign_s1;
            exp_s2      <= major_exp_s1;
            sum_s2      <= sum[26:0];
            carry_s2    <= sum[27];
            eff_sub_s2  <= eff_sub;
            invalid_s2  <= invalid_s1;
            inf_s2      <= inf_s1;
            rnd_mode_s2 <= rnd_mode_s1;
        end
    end : stage2_reg

    // ----------------------------------------------------------------------
    // stage 3: normalize and form guard, round, sticky.
    // ----------------------------------------------------------------------

    logic [LZ_W-1:0] lz_count;
    logic            sig_all_zero;

    count_leading_zeros #(
        .WIDTH (SIG_W)
    ) u_clz (
        .operand_i     (sum_s2[26:3]),
        .lz_count_o    (lz_count),
        .is_all_zero_o (sig_all_zero)
    );

    logic                       is_zero;
    logic [26:0]                norm_ext;
    logic [7:0]                 norm_exp;
    logic                       norm_ovf;
    logic                       norm_unf;
    fp_format_pkg::float32_t    norm_result;
    fp_format_pkg::round_bits_t norm_rb;

    assign is_zero = sig_all_zero & (sum_s2[2:0] == 3'b000) & ~carry_s2;

    always_comb begin : normalize
        norm_ext = sum_s2;
        norm_exp = exp_s2;
        norm_ovf = 1'b0;
        norm_unf = 1'b0;
        if (carry_s2) begin
            // one place right, the dropped bit folds into sticky.
            norm_ext = {1'b1, sum_s2[26:2], |sum_s2[1:0]};
            norm_exp = exp_s2 + 8'd1;
            norm_ovf = (exp_s2 == fp_format_pkg::MAX_EXP);
        end else if ({1'b0, exp_s2} > {{(9 - LZ_W){1'b0}}, lz_count}) begin
            norm_ext = sum_s2 << lz_count;
            norm_exp = exp_s2 - {{(8 - LZ_W){1'b0}}, lz_count};
        end else begin
            // clamped at MIN_EXP scale, stored as subnormal.
            norm_ext = sum_s2 << (exp_s2[LZ_W-1:0] - LZ_W'(fp_format_pkg::MIN_EXP));
            norm_exp = '0;
            norm_unf = 1'b1;
        end

        norm_result = {sign_s2, norm_exp, norm_ext[25:3]};
        norm_rb     = norm_ext[2:0];

        if (invalid_s2 || inf_s2 || norm_ovf) begin
            norm_result = {sign_s2, fp_format_pkg::INF_EXP, 23'b0};
            norm_rb     = '0;
        end else if (is_zero) begin
            // exact cancellation gives +0.
            norm_result = {sign_s2 & ~eff_sub_s2, 31'b0};
            norm_rb     = '0;
            norm_unf    = 1'b0;
        end
    end : normalize

    fp_format_pkg::float32_t    result_s3;
    fp_format_pkg::round_bits_t round_bits_s3;
    logic                       overflow_s3;
    logic                       underflow_s3;
    logic                       invalid_s3;
    fp_ops_pkg::round_mode_t    rnd_mode_s3;

    always_ff @(posedge clk_i) begin : stage3_reg
        if (clk_en_i) begin
            result_s3     <= norm_result;
            round_bits_s3 <= norm_rb;
            overflow_s3   <= norm_ovf;
            underflow_s3  <= norm_unf;
            invalid_s3    <= invalid_s2;
            rnd_mode_s3   <= rnd_mode_s2;
        end
    end : stage3_reg

    assign res_o.result     = result_s3;
    assign res_o.valid      = valid_pipe[3];
    assign res_o.round_bits = round_bits_s3;
    assign res_o.invalid    = invalid_s3;
    assign res_o.overflow   = overflow_s3;
    assign res_o.underflow  = underflow_s3;
    assign res_o.rnd_mode   = rnd_mode_s3;

endmodule : floating_point_adder

// File: fp_adder/count_leading_zeros.sv
`timescale 1ns/10ps

module count_leading_zeros #(
    parameter  int WIDTH = 24,
    localparam int CNT_W = $clog2(WIDTH + 1)
) (
    input  logic [WIDTH-1:0] operand_i,
    output logic [CNT_W-1:0] lz_count_o,
    output logic             is_all_zero_o
);

    // ----------------------------------------------------------------------
    // priority search.
    // ----------------------------------------------------------------------

    // scan from the lsb up, so the highest set bit wins.
    always_comb begin : lz_search
        lz_count_o = CNT_W'(WIDTH);
        for (int i = 0; i < WIDTH; i++) begin
            if (operand_i[i]) begin
                lz_count_o = CNT_W'(WIDTH - 1 - i);
            end
        end
    end : lz_search

    // count is WIDTH in this case.
    assign is_all_zero_o = (operand_i == '0);

endmodule : count_leading_zeros

// File: common/fpadd_result_if.sv
`timescale 1ns/10ps

// unrounded adder output, meaningful only while valid is high.
interface fpadd_result_if;

    fp_format_pkg::float32_t    result;
    logic                       valid;
    fp_format_pkg::round_bits_t round_bits;
    logic                       invalid;
    logic                       overflow;
    logic                       underflow;
    fp_ops_pkg::round_mode_t    rnd_mode;

    modport producer (
        output result, valid, round_bits, invalid, overflow, underflow, rnd_mode
    );

    modport consumer (
        input  result, valid, round_bits, invalid, overflow, underflow, rnd_mode
    );

endinterface : fpadd_result_if

// File: common/fp_ops_pkg.sv
package fp_ops_pkg;

    // add or subtract select.
    typedef enum logic {
        FADD = 1'b0,
        FSUB = 1'b1
    } fpadd_operation_t;

    // supported rounding modes.
    typedef enum logic {
        RNE = 1'b0,
        RTZ = 1'b1
    } round_mode_t;

    // ----------------------------------------------------------------------
    // exception flags reported with each result.
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

endpackage : fp_ops_pkg

// File: common/fp_format_pkg.sv
package fp_format_pkg;

    // ----------------------------------------------------------------------
    // float32 field widths.
    // ----------------------------------------------------------------------

    localparam int EXP_W  = 8;
    localparam int MANT_W = 23;

    // ieee 754 single precision layout, sign in the msb.
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [MANT_W-1:0] mantissa;
    } float32_t;

    // bits below the last mantissa place, guard first.
    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } round_bits_t;

    // ----------------------------------------------------------------------
    // exponent limits and special encodings.
    // ----------------------------------------------------------------------

    localparam logic [EXP_W-1:0] MAX_EXP = 8'd254;
    localparam logic [EXP_W-1:0] MIN_EXP = 8'd1;
    localparam logic [EXP_W-1:0] INF_EXP = 8'd255;

    // positive quiet nan, the only nan this unit produces.
    localparam logic [31:0] CANONICAL_NAN = 32'h7FC0_0000;

endpackage : fp_format_pkg
